// File: hw/pixel_bus_pkg.sv
package pixel_bus_pkg;

    localparam int adr_width = 16;
    localparam int dat_width = 32;

    // output fifo
    localparam logic [adr_width-1:0] fifo_base = 16'h0020;
    localparam logic [adr_width-1:0] fifo_count_ofs = 16'h0000;
    localparam logic [adr_width-1:0] fifo_data_ofs = 16'h0001;

    // shift-register receiver
    localparam logic [adr_width-1:0] sr_rx_base = 16'h0100;
    localparam logic [adr_width-1:0] sr_rx_lost_ofs = 16'h0000;

    localparam logic [adr_width-1:0] tdc_base = 16'h0200;
    localparam logic [adr_width-1:0] tdc_arm_ofs = 16'h0000;
    localparam logic [adr_width-1:0] tdc_lost_ofs = 16'h0001;

    // sequencer control regs with the pattern memory above them
    localparam logic [adr_width-1:0] seq_base = 16'h1000;
    localparam logic [adr_width-1:0] seq_size_ofs = 16'h0000;
    localparam logic [adr_width-1:0] seq_start_ofs = 16'h0001;
    localparam logic [adr_width-1:0] seq_busy_ofs = 16'h0002;
    localparam logic [adr_width-1:0] seq_mem_ofs = 16'h0100;
    localparam int seq_mem_bytes = 256;

    localparam logic [adr_width-1:0] slave_span = 16'h0400;

endpackage

// File: hw/pixel_data_pkg.sv
package pixel_data_pkg;

    // identifier nibble sits on top in both layouts
    typedef struct packed {
        logic [3:0]  id;
        logic [11:0] reserved;
        logic [15:0] width;
    } tdc_word_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [11:0] frame;
        logic [15:0] data;
    } sr_word_t;

    typedef union packed {
        tdc_word_t tdc;
        sr_word_t  sr;
    } readout_word_u;

    localparam logic [3:0] id_tdc = 4'b0100;
    localparam logic [3:0] id_sr = 4'b0010;

    localparam int unsigned fifo_depth = 16;

    // bit positions in the sequencer byte
    // bits 6 and 7 spare
    typedef enum logic [2:0] {
        sr_in         = 3'd0,
        global_sr_en  = 3'd1,
        global_ctr_ld = 3'd2,
        global_dac_ld = 3'd3,
        pixel_sr_en   = 3'd4,
        inject        = 3'd5
    } seq_bit_e;

endpackage

// File: hw/wb_if.sv
interface wb_if;

    logic                                cyc;
    logic                                stb;
    logic                                we;
    logic [pixel_bus_pkg::adr_width-1:0] adr;
    logic [pixel_bus_pkg::dat_width-1:0] wdata;
    logic [pixel_bus_pkg::dat_width-1:0] rdata;
    logic                                ack;

    modport master (
        output cyc, stb, we, adr, wdata,
        input  rdata, ack
    );

    modport slave (
        input  cyc, stb, we, adr, wdata,
        output rdata, ack
    );

endinterface

// File: hw/bus_decoder.sv
module bus_decoder (
    input logic bus_clk,
    input logic rst_n,
    wb_if.slave host,
    wb_if.master fifo_bus,
    wb_if.master sr_bus,
    wb_if.master tdc_bus,
    wb_if.master seq_bus
);

    logic sel_fifo, sel_sr, sel_tdc, sel_seq, sel_none;
    logic def_ack;

    function automatic logic in_span(input logic [pixel_bus_pkg::adr_width-1:0] adr,
                                     input logic [pixel_bus_pkg::adr_width-1:0] base);
        return adr >= base && (adr - base) < pixel_bus_pkg::slave_span;
    endfunction

    // spans overlap at the low end, so the highest matching base wins
    always_comb begin
        sel_seq = in_span(host.adr, pixel_bus_pkg::seq_base);
        sel_tdc = !sel_seq && in_span(host.adr, pixel_bus_pkg::tdc_base);
        sel_sr = !sel_seq && !sel_tdc && in_span(host.adr, pixel_bus_pkg::sr_rx_base);
        sel_fifo = !sel_seq && !sel_tdc && !sel_sr
                   && in_span(host.adr, pixel_bus_pkg::fifo_base);
        sel_none = !(sel_seq || sel_tdc || sel_sr || sel_fifo);
    end

    // slaves see offsets relative to their own base
    assign fifo_bus.cyc = host.cyc;
    assign fifo_bus.we = host.we;
    assign fifo_bus.wdata = host.wdata;
    assign fifo_bus.adr = host.adr - pixel_bus_pkg::fifo_base;
    assign fifo_bus.stb = host.stb && sel_fifo;

    assign sr_bus.cyc = host.cyc;
    assign sr_bus.we = host.we;
    assign sr_bus.wdata = host.wdata;
    assign sr_bus.adr = host.adr - pixel_bus_pkg::sr_rx_base;
    assign sr_bus.stb = host.stb && sel_sr;

    assign tdc_bus.cyc = host.cyc;
    assign tdc_bus.we = host.we;
    assign tdc_bus.wdata = host.wdata;
    assign tdc_bus.adr = host.adr - pixel_bus_pkg::tdc_base;
    assign tdc_bus.stb = host.stb && sel_tdc;

    assign seq_bus.cyc = host.cyc;
    assign seq_bus.we = host.we;
    assign seq_bus.wdata = host.wdata;
    assign seq_bus.adr = host.adr - pixel_bus_pkg::seq_base;
    assign seq_bus.stb = host.stb && sel_seq;

    // unmapped access still gets an ack so the host never stalls
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            def_ack <= 1'b0;
        end else begin
            def_ack <= host.cyc && host.stb && sel_none && !def_ack;
        end
    end

    assign host.ack = fifo_bus.ack || sr_bus.ack || tdc_bus.ack || seq_bus.ack || def_ack;

    always_comb begin
        if (sel_seq) begin
            host.rdata = seq_bus.rdata;
        end else if (sel_tdc) begin
            host.rdata = tdc_bus.rdata;
        end else if (sel_sr) begin
            host.rdata = sr_bus.rdata;
        end else if (sel_fifo) begin
            host.rdata = fifo_bus.rdata;
        end else begin
            host.rdata = '0;
        end
    end

endmodule

// File: hw/seq_gen.sv
module seq_gen (
    input logic bus_clk,
    input logic rst_n,
    wb_if.slave bus,
    output logic [7:0] seq_out
);

    logic [7:0] mem [pixel_bus_pkg::seq_mem_bytes];
    logic [7:0] mem_idx;
    logic [8:0] size;
    logic [8:0] ptr;
    logic       busy;
    logic       req, in_mem, start;

    assign req = bus.cyc && bus.stb && !bus.ack;
    assign mem_idx = bus.adr[7:0];
    // aligned 256 byte window
    assign in_mem = bus.adr[15:8] == pixel_bus_pkg::seq_mem_ofs[15:8];
    assign start = req && bus.we && bus.adr == pixel_bus_pkg::seq_start_ofs;

    always_ff @(posedge bus_clk) begin
        if (req && bus.we && in_mem) begin
            mem[mem_idx] <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            bus.ack <= 1'b0;
            size <= '0;
            ptr <= '0;
            busy <= 1'b0;
            seq_out <= '0;
        end else begin
            bus.ack <= bus.cyc && bus.stb && !bus.ack;
            if (req && bus.we && bus.adr == pixel_bus_pkg::seq_size_ofs) begin
                size <= bus.wdata[8:0];
            end
            // restart from byte zero even mid-playback
            if (start) begin
                busy <= 1'b1;
                ptr <= '0;
            end else if (busy) begin
                if (ptr == size) begin
                    seq_out <= '0;
                    busy <= 1'b0;
                end else begin
                    seq_out <= mem[ptr[7:0]];
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        bus.rdata <= '0;
        if (req && !bus.we) begin
            if (in_mem) begin
                bus.rdata[7:0] <= mem[mem_idx];
            end else if (bus.adr == pixel_bus_pkg::seq_size_ofs) begin
                bus.rdata[8:0] <= size;
            end else if (bus.adr == pixel_bus_pkg::seq_busy_ofs) begin
                bus.rdata[0] <= busy;
            end
        end
    end

endmodule

// File: hw/fast_sr_rx.sv
module fast_sr_rx (
    input logic bus_clk,
    input logic rst_n,
    wb_if.slave bus,
    input logic sen,
    input logic sdi,
    output pixel_data_pkg::readout_word_u word,
    output logic valid,
    input logic grant
);

    logic [15:0] shift;
    logic [3:0]  cnt;
    logic [11:0] frame;
    logic [15:0] lost;
    logic        formed, pending, take;

    // 16th sample of a group completes a word
    assign formed = sen && cnt == 4'd15;
    assign pending = valid && !grant;
    assign take = formed && !pending;

    always_ff @(posedge bus_clk) begin
        if (sen) begin
            shift <= {shift[14:0], sdi};
        end
        if (take) begin
            word.sr.id <= pixel_data_pkg::id_sr;
            word.sr.frame <= frame;
            word.sr.data <= {shift[14:0], sdi};
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            cnt <= '0;
            frame <= '0;
            valid <= 1'b0;
            lost <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.cyc && bus.stb && !bus.ack;
            // partial group is thrown away when enable drops
            if (sen) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
            if (take) begin
                valid <= 1'b1;
                frame <= frame + 1'b1;
            end else if (grant) begin
                valid <= 1'b0;
            end
            if (formed && pending) begin
                lost <= lost + 1'b1;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        bus.rdata <= '0;
        if (bus.cyc && bus.stb && !bus.ack && !bus.we
                && bus.adr == pixel_bus_pkg::sr_rx_lost_ofs) begin
            bus.rdata[15:0] <= lost;
        end
    end

endmodule

// File: hw/tdc.sv
module tdc (
    input logic bus_clk,
    input logic rst_n,
    wb_if.slave bus,
    input logic hit,
    output pixel_data_pkg::readout_word_u word,
    output logic valid,
    input logic grant
);

    logic        hit_d, armed, meas;
    logic [15:0] width;
    logic [15:0] lost;
    logic        req, done, pending, take;

    assign req = bus.cyc && bus.stb && !bus.ack;
    // first low cycle after a pulse that started while armed
    assign done = meas && hit_d && !hit;
    assign pending = valid && !grant;
    assign take = done && !pending;

    always_ff @(posedge bus_clk) begin
        if (take) begin
            word.tdc.id <= pixel_data_pkg::id_tdc;
            word.tdc.reserved <= '0;
            word.tdc.width <= width;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            hit_d <= 1'b0;
            armed <= 1'b0;
            meas <= 1'b0;
            width <= '0;
            valid <= 1'b0;
            lost <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.cyc && bus.stb && !bus.ack;
            hit_d <= hit;
            if (req && bus.we && bus.adr == pixel_bus_pkg::tdc_arm_ofs) begin
                armed <= bus.wdata[0];
            end
            if (hit && !hit_d) begin
                meas <= armed;
                width <= 16'd1;
            end else if (hit && width != 16'hffff) begin
                width <= width + 1'b1;
            end
            if (done) begin
                meas <= 1'b0;
            end
            if (take) begin
                valid <= 1'b1;
            end else if (grant) begin
                valid <= 1'b0;
            end
            if (done && pending) begin
                lost <= lost + 1'b1;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        bus.rdata <= '0;
        if (req && !bus.we) begin
            if (bus.adr == pixel_bus_pkg::tdc_arm_ofs) begin
                bus.rdata[0] <= armed;
            end else if (bus.adr == pixel_bus_pkg::tdc_lost_ofs) begin
                bus.rdata[15:0] <= lost;
            end
        end
    end

endmodule

// File: hw/rr_arbiter.sv
module rr_arbiter (
    input logic bus_clk,
    input logic rst_n,
    input pixel_data_pkg::readout_word_u sr_word,
    input logic sr_valid,
    output logic sr_grant,
    input pixel_data_pkg::readout_word_u tdc_word,
    input logic tdc_valid,
    output logic tdc_grant,
    input logic full,
    output logic wr,
    output pixel_data_pkg::readout_word_u wr_data
);

    // set when the receiver won last, cleared when the tdc did
    logic last_sr;

    always_comb begin
        sr_grant = 1'b0;
        tdc_grant = 1'b0;
        if (!full) begin
            if (sr_valid && (!tdc_valid || !last_sr)) begin
                sr_grant = 1'b1;
            end else if (tdc_valid) begin
                tdc_grant = 1'b1;
            end
        end
    end

    assign wr = sr_grant || tdc_grant;
    assign wr_data = sr_grant ? sr_word : tdc_word;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            last_sr <= 1'b0;
        end else if (sr_grant) begin
            last_sr <= 1'b1;
        end else if (tdc_grant) begin
            last_sr <= 1'b0;
        end
    end

endmodule

// File: hw/out_fifo.sv
module out_fifo (
    input logic bus_clk,
    input logic rst_n,
    wb_if.slave bus,
    input logic wr,
    input pixel_data_pkg::readout_word_u wr_data,
    output logic full
);

    pixel_data_pkg::readout_word_u mem [pixel_data_pkg::fifo_depth];
    logic [$clog2(pixel_data_pkg::fifo_depth)-1:0]   wr_ptr, rd_ptr;
    logic [$clog2(pixel_data_pkg::fifo_depth+1)-1:0] count;
    logic req, rd_data, pop;

    assign req = bus.cyc && bus.stb && !bus.ack && !bus.we;
    assign rd_data = req && bus.adr == pixel_bus_pkg::fifo_data_ofs;
    // reading an empty fifo pops nothing
    assign pop = rd_data && count != '0;
    assign full = count == ($bits(count))'(pixel_data_pkg::fifo_depth);

    always_ff @(posedge bus_clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.cyc && bus.stb && !bus.ack;
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        bus.rdata <= '0;
        if (pop) begin
            bus.rdata <= mem[rd_ptr];
        end else if (req && bus.adr == pixel_bus_pkg::fifo_count_ofs) begin
            bus.rdata[$bits(count)-1:0] <= count;
        end
    end

endmodule

// File: hw/pixel_top.sv
module pixel_top (
    input logic bus_clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [pixel_bus_pkg::adr_width-1:0] wb_adr,
    input logic [pixel_bus_pkg::dat_width-1:0] wb_wdata,
    output logic [pixel_bus_pkg::dat_width-1:0] wb_rdata,
    output logic wb_ack,
    output logic sr_in,
    output logic global_sr_en,
    output logic global_ctr_ld,
    output logic global_dac_ld,
    output logic pixel_sr_en,
    output logic inject,
    input logic pixel_sr_out,
    input logic hit_or
);

    wb_if host_bus ();
    wb_if fifo_bus ();
    wb_if sr_bus ();
    wb_if tdc_bus ();
    wb_if seq_bus ();

    logic [7:0] seq_out;
    pixel_data_pkg::readout_word_u sr_word, tdc_word, fifo_wr_data;
    logic sr_valid, sr_grant, tdc_valid, tdc_grant;
    logic fifo_full, fifo_wr;

    assign host_bus.cyc = wb_cyc;
    assign host_bus.stb = wb_stb;
    assign host_bus.we = wb_we;
    assign host_bus.adr = wb_adr;
    assign host_bus.wdata = wb_wdata;
    assign wb_rdata = host_bus.rdata;
    assign wb_ack = host_bus.ack;

    // chip control lines straight from the sequencer byte
    assign sr_in = seq_out[pixel_data_pkg::sr_in];
    assign global_sr_en = seq_out[pixel_data_pkg::global_sr_en];
    assign global_ctr_ld = seq_out[pixel_data_pkg::global_ctr_ld];
    assign global_dac_ld = seq_out[pixel_data_pkg::global_dac_ld];
    assign pixel_sr_en = seq_out[pixel_data_pkg::pixel_sr_en];
    assign inject = seq_out[pixel_data_pkg::inject];

    bus_decoder i_bus_decoder (
        .bus_clk, .rst_n, .host(host_bus),
        .fifo_bus, .sr_bus, .tdc_bus, .seq_bus
    );

    seq_gen i_seq_gen (.bus_clk, .rst_n, .bus(seq_bus), .seq_out);

    fast_sr_rx i_fast_sr_rx (
        .bus_clk, .rst_n, .bus(sr_bus), .sen(pixel_sr_en), .sdi(pixel_sr_out),
        .word(sr_word), .valid(sr_valid), .grant(sr_grant)
    );

    tdc i_tdc (
        .bus_clk, .rst_n, .bus(tdc_bus), .hit(hit_or),
        .word(tdc_word), .valid(tdc_valid), .grant(tdc_grant)
    );

    rr_arbiter i_rr_arbiter (
        .bus_clk, .rst_n, .sr_word, .sr_valid, .sr_grant,
        .tdc_word, .tdc_valid, .tdc_grant,
        .full(fifo_full), .wr(fifo_wr), .wr_data(fifo_wr_data)
    );

    out_fifo i_out_fifo (
        .bus_clk, .rst_n, .bus(fifo_bus),
        .wr(fifo_wr), .wr_data(fifo_wr_data), .full(fifo_full)
    );

endmodule

// File: verification/pixel_checker.sv
module pixel_checker (
    input logic        bus_clk,
    input logic        rst_n,
    input logic        wb_ack,
    input logic [31:0] wb_rdata,
    input logic [5:0]  lines
);

    int          mismatches;
    int          other_errors;
    logic [31:0] sr_q [$];
    logic [31:0] tdc_q [$];
    logic        ack_prev;

    initial begin
        mismatches = 0;
        other_errors = 0;
        ack_prev = 1'b0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic fail(input string what);
        other_errors++;
        $display("ERROR: %s", what);
    endtask

    // read data is sampled on the ack cycle
    task automatic check_value(input string name, input logic [31:0] exp);
        compare(name, exp, wb_rdata);
    endtask

    task automatic expect_word(input logic [31:0] w);
        if (w[31:28] == pixel_data_pkg::id_sr) begin
            sr_q.push_back(w);
        end else begin
            tdc_q.push_back(w);
        end
    endtask

    // words of the two sources interleave freely
    // order only holds per identifier
    task automatic check_word(input string name);
        logic [3:0]  id;
        logic [31:0] exp;
        id = wb_rdata[31:28];
        if (id == pixel_data_pkg::id_sr && sr_q.size() > 0) begin
            exp = sr_q.pop_front();
            compare(name, exp, wb_rdata);
        end else if (id == pixel_data_pkg::id_tdc && tdc_q.size() > 0) begin
            exp = tdc_q.pop_front();
            compare(name, exp, wb_rdata);
        end else begin
            fail($sformatf("%s: FIFO returned %h, which no source should have sent",
                           name, wb_rdata));
        end
    endtask

    task automatic check_lines(input string name, input logic [7:0] exp);
        compare(name, {26'h0, exp[5:0]}, {26'h0, lines});
    endtask

    // ack is a single-cycle pulse
    always @(negedge bus_clk) begin
        if (rst_n && wb_ack && ack_prev) begin
            fail("bus ack stayed high for more than one cycle");
        end
        ack_prev = wb_ack;
    end

    function automatic int error_count();
        return mismatches + other_errors;
    endfunction

    task automatic report();
        if (sr_q.size() + tdc_q.size() > 0) begin
            fail($sformatf("%0d expected words never came out of the FIFO",
                           sr_q.size() + tdc_q.size()));
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
    endtask

endmodule

// File: verification/pixel_tb.sv
module pixel_tb;

    localparam int clk_period = 100;
    // upper bounds of each test in clock cycles
    localparam int access_len = 200;
    localparam int seq_len = 2400;
    localparam int capture_len = 1200;
    localparam int tdc_len = 3000;
    localparam int merge_len = 1300;
    localparam int watchdog_cycles =
        2 * (access_len + seq_len + capture_len + tdc_len + merge_len);

    logic        bus_clk, rst_n;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [15:0] wb_adr;
    logic [31:0] wb_wdata, wb_rdata;
    logic        sr_in, global_sr_en, global_ctr_ld, global_dac_ld, pixel_sr_en, inject;
    logic        pixel_sr_out, hit_or;

    // model state
    logic [7:0]  pat [256];
    logic        hit_pat [256];
    logic [15:0] sr_shift;
    logic [11:0] frame;
    int          sr_cnt, held, lost_sr, lost_tdc, tdc_width;
    logic        pend_sr, pend_tdc, tdc_armed, tdc_meas, hit_prev;

    pixel_top i_dut (.*);

    pixel_checker i_checker (
        .bus_clk, .rst_n, .wb_ack, .wb_rdata,
        .lines({inject, pixel_sr_en, global_dac_ld, global_ctr_ld, global_sr_en, sr_in})
    );

    initial begin
        bus_clk = 1'b0;
        forever #(clk_period / 2) bus_clk = ~bus_clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        i_checker.fail("watchdog expired before the tests finished");
        i_checker.report();
        $display("Regression failed");
        $finish;
    end

    task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge bus_clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_wdata = data;
        while (waited == 0 || (!wb_ack && waited < 16)) begin
            @(negedge bus_clk);
            waited++;
        end
        if (!wb_ack) begin
            i_checker.fail($sformatf("no ack for the access to address %h", adr));
        end
        // address stays put so read data holds while the checker samples it
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [15:0] adr, input logic [31:0] exp);
        bus_access(1'b0, adr, 32'h0);
        i_checker.check_value(name, exp);
    endtask

    // keep, hold pending behind a full FIFO, or drop
    function automatic logic accept_word(input logic is_sr);
        int in_fifo;
        in_fifo = held - int'(pend_sr) - int'(pend_tdc);
        if (is_sr ? pend_sr : pend_tdc) begin
            if (is_sr) begin
                lost_sr++;
            end else begin
                lost_tdc++;
            end
            return 1'b0;
        end
        if (in_fifo == pixel_data_pkg::fifo_depth) begin
            if (is_sr) begin
                pend_sr = 1'b1;
            end else begin
                pend_tdc = 1'b1;
            end
        end
        held++;
        return 1'b1;
    endfunction

    // one clock of both sources with the inputs seen at the coming edge
    task automatic model_cycle(input logic sen, input logic sdi, input logic hit);
        pixel_data_pkg::readout_word_u w;
        if (sen) begin
            sr_shift = {sr_shift[14:0], sdi};
            sr_cnt++;
        end else begin
            sr_cnt = 0;
        end
        if (sr_cnt == 16) begin
            sr_cnt = 0;
            if (accept_word(1'b1)) begin
                w.sr.id = pixel_data_pkg::id_sr;
                w.sr.frame = frame;
                w.sr.data = sr_shift;
                i_checker.expect_word(w);
                frame++;
            end
        end
        if (hit && !hit_prev) begin
            tdc_meas = tdc_armed;
            tdc_width = 1;
        end else if (hit && tdc_width < 65535) begin
            tdc_width++;
        end else if (!hit && hit_prev && tdc_meas) begin
            tdc_meas = 1'b0;
            if (accept_word(1'b0)) begin
                w.tdc.id = pixel_data_pkg::id_tdc;
                w.tdc.reserved = 12'h0;
                w.tdc.width = 16'(tdc_width);
                i_checker.expect_word(w);
            end
        end
        hit_prev = hit;
    endtask

    task automatic set_byte(input int k, input logic sen, input logic hit);
        pat[k] = 8'($urandom);
        pat[k][pixel_data_pkg::pixel_sr_en] = sen;
        hit_pat[k] = hit;
    endtask

    task automatic play(input string name, input int n);
        logic [7:0] cur;
        for (int i = 0; i < n; i++) begin
            bus_access(1'b1, 16'(pixel_bus_pkg::seq_base + pixel_bus_pkg::seq_mem_ofs + i),
                       {24'h0, pat[i]});
        end
        bus_access(1'b1, pixel_bus_pkg::seq_base + pixel_bus_pkg::seq_size_ofs, 32'(n));
        bus_access(1'b1, pixel_bus_pkg::seq_base + pixel_bus_pkg::seq_start_ofs, 32'h1);
        // byte 0 is out one cycle after the start ack
        // the lines go low once the pattern ends
        for (int k = 0; k <= n + 2; k++) begin
            @(negedge bus_clk);
            cur = (k < n) ? pat[k] : 8'h00;
            i_checker.check_lines(name, cur);
            pixel_sr_out = 1'($urandom);
            hit_or = (k < n) ? hit_pat[k] : 1'b0;
            model_cycle(cur[pixel_data_pkg::pixel_sr_en], pixel_sr_out, hit_or);
        end
        read_check(name, pixel_bus_pkg::seq_base + pixel_bus_pkg::seq_busy_ofs, 32'h0);
    endtask

    task automatic pulse(input int width);
        for (int k = 0; k < width + 3; k++) begin
            @(negedge bus_clk);
            hit_or = k < width;
            model_cycle(1'b0, 1'b0, hit_or);
        end
    endtask

    task automatic drain(input string name);
        while (held > 0) begin
            bus_access(1'b0, pixel_bus_pkg::fifo_base + pixel_bus_pkg::fifo_data_ofs, 32'h0);
            i_checker.check_word(name);
            held--;
        end
        pend_sr = 1'b0;
        pend_tdc = 1'b0;
        read_check(name, pixel_bus_pkg::fifo_base + pixel_bus_pkg::fifo_count_ofs, 32'h0);
        // empty FIFO reads as zero
        read_check(name, pixel_bus_pkg::fifo_base + pixel_bus_pkg::fifo_data_ofs, 32'h0);
    endtask

    task automatic set_arm(input logic arm);
        bus_access(1'b1, pixel_bus_pkg::tdc_base + pixel_bus_pkg::tdc_arm_ofs, {31'h0, arm});
        tdc_armed = arm;
    endtask

    initial begin
        logic [7:0]  idx [12];
        logic [31:0] data;
        logic        arm;
        int          k, run, gap, w;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 16'h0;
        wb_wdata = 32'h0;
        pixel_sr_out = 1'b0;
        hit_or = 1'b0;
        sr_shift = 16'h0;
        frame = 12'h0;
        sr_cnt = 0;
        held = 0;
        lost_sr = 0;
        lost_tdc = 0;
        tdc_width = 0;
        pend_sr = 1'b0;
        pend_tdc = 1'b0;
        tdc_armed = 1'b0;
        tdc_meas = 1'b0;
        hit_prev = 1'b0;
        void'($urandom(92570));
        repeat (4) @(negedge bus_clk);
        rst_n = 1'b1;

        // register access
        for (int i = 0; i < 12; i++) begin
            idx[i] = 8'($urandom);
            data = $urandom;
            pat[idx[i]] = data[7:0];
            bus_access(1'b1, pixel_bus_pkg::seq_base + pixel_bus_pkg::seq_mem_ofs + idx[i], data);
        end
        for (int i = 0; i < 12; i++) begin
            read_check("register access",
                       pixel_bus_pkg::seq_base + pixel_bus_pkg::seq_mem_ofs + idx[i],
                       {24'h0, pat[idx[i]]});
        end
        arm = 1'($urandom);
        set_arm(arm);
        read_check("register access", pixel_bus_pkg::tdc_base + pixel_bus_pkg::tdc_arm_ofs,
                   {31'h0, arm});
        read_check("register access", 16'h0800 + 16'($urandom_range(16'h07ff, 0)), 32'h0);
        read_check("register access", 16'h1400 + 16'($urandom_range(16'hebff, 0)), 32'h0);
        set_arm(1'b0);

        // sequence playback with the receiver enable kept low
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 256; i++) begin
                set_byte(i, 1'b0, 1'b0);
            end
            play("sequence playback", int'($urandom_range(256, 1)));
        end

        // whole groups of 16 with a partial one now and then
        k = 0;
        while (k < 220) begin
            if ($urandom_range(3, 0) == 0) begin
                run = int'($urandom_range(15, 1));
            end else begin
                run = 16 * int'($urandom_range(2, 1));
            end
            gap = int'($urandom_range(3, 1));
            for (int j = 0; j < run + gap; j++) begin
                set_byte(k, j < run, 1'b0);
                k++;
            end
        end
        play("shift-register capture", k);
        drain("shift-register capture");

        // tdc armed and then disarmed
        set_arm(1'b1);
        repeat (6) pulse(int'($urandom_range(300, 1)));
        drain("tdc");
        set_arm(1'b0);
        repeat (2) pulse(int'($urandom_range(300, 1)));
        read_check("tdc", pixel_bus_pkg::fifo_base + pixel_bus_pkg::fifo_count_ofs, 32'h0);

        // both sources into a FIFO nobody reads
        // hit falls well before each sr word
        set_arm(1'b1);
        for (int g = 0; g < 12; g++) begin
            w = int'($urandom_range(12, 1));
            for (int j = 0; j < 20; j++) begin
                set_byte(g * 20 + j, j < 16, j < w);
            end
        end
        play("merge", 240);
        read_check("merge", pixel_bus_pkg::fifo_base + pixel_bus_pkg::fifo_count_ofs,
                   32'(held - int'(pend_sr) - int'(pend_tdc)));
        read_check("merge", pixel_bus_pkg::sr_rx_base + pixel_bus_pkg::sr_rx_lost_ofs,
                   32'(lost_sr));
        read_check("merge", pixel_bus_pkg::tdc_base + pixel_bus_pkg::tdc_lost_ofs,
                   32'(lost_tdc));
        drain("merge");

        i_checker.report();
        if (i_checker.error_count() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: all.f
hw/pixel_bus_pkg.sv
hw/pixel_data_pkg.sv
hw/wb_if.sv
hw/bus_decoder.sv
hw/seq_gen.sv
hw/fast_sr_rx.sv
hw/tdc.sv
hw/rr_arbiter.sv
hw/out_fifo.sv
hw/pixel_top.sv
verification/pixel_checker.sv
verification/pixel_tb.sv

// File: Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module pixel_tb -f all.f -o pixel_sim
	./obj_dir/pixel_sim | tee /dev/stderr | grep -q "Regression passed"

lint:
	verilator --lint-only -Wall --timing --top-module pixel_tb -f all.f

clean:
	rm -rf obj_dir
